/* Makefile */
# Verilator build and run of the test signal testbench

TOP := tb_test_signal

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f list.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

/* audio/i2s_tone_gen.sv */
////////////////////////////////////////////////////////////
// i2s square tone source
// bit clock enable, word clock and a square wave level that
// flips every tone_half_period channel slots
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module i2s_tone_gen #(
  parameter int tone_half_period = 109
) (
  input  logic audgen_mclk,
  input  logic reset_n,
  output logic audio_sclk,
  output logic audio_lrck,
  output logic audio_dac
);
  import audio_pkg::*;

  localparam int div_w = $clog2(sclk_div);
  localparam int cnt_w = $clog2(bits_per_channel);
  localparam int osc_w = $clog2(tone_half_period + 1);

  localparam logic [div_w-1:0] div_last = div_w'(sclk_div - 1);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(bits_per_channel - 1);
  localparam logic [cnt_w-1:0] lead_end = cnt_w'(dac_lead_zero_bits);
  localparam logic [osc_w-1:0] osc_top  = osc_w'(tone_half_period);

  logic [div_w-1:0] div;
  logic [cnt_w-1:0] bit_cnt;
  logic [osc_w-1:0] osc;
  logic             tone_high;
  logic             bit_tick;
  logic             slot_wrap;

  ////////////////////////////////////////////////////////////
  // bit clock
  ////////////////////////////////////////////////////////////

  // tick lines up with the falling edge of sclk
  assign bit_tick   = (div == div_last);
  assign audio_sclk = div[div_w-1];
  // last bit of a channel slot
  assign slot_wrap  = bit_tick && (bit_cnt == cnt_last);

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      div <= '0;
    end else begin
      div <= div + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // framing and tone
  ////////////////////////////////////////////////////////////

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      bit_cnt    <= '0;
      audio_lrck <= 1'b0;
      audio_dac  <= 1'b0;
      osc        <= osc_w'(1);
      tone_high  <= 1'b0;
    end else if (bit_tick) begin
      // leading zeros, then the tone level
      audio_dac <= (bit_cnt < lead_end) ? 1'b0 : tone_high;
      bit_cnt   <= bit_cnt + 1'b1;
      if (slot_wrap) begin
        // next channel
        audio_lrck <= ~audio_lrck;
        if (osc < osc_top) begin
          osc <= osc + 1'b1;
        end else begin
          osc       <= osc_w'(1);
          tone_high <= ~tone_high;
        end
      end
    end
  end

  // word clock only moves at a slot boundary
  a_lrck_on_wrap : assert property (@(posedge audgen_mclk) disable iff (!reset_n)
    $changed(audio_lrck) |-> $past(slot_wrap));

endmodule

`default_nettype wire

/* common/audio_pkg.sv */
////////////////////////////////////////////////////////////
// i2s framing constants
// bit clock ratio and channel slot layout
////////////////////////////////////////////////////////////

`default_nettype none

package audio_pkg;

  // master clocks per serial bit
  localparam int sclk_div = 4;

  // bit slots per channel, one lrck half period
  localparam int bits_per_channel = 32;

  // zero bits at the start of each channel slot
  // keeps the tone at a low volume
  localparam int dac_lead_zero_bits = 4;

endpackage

`default_nettype wire

/* common/video_pkg.sv */
////////////////////////////////////////////////////////////
// video test-signal constants
// pixel and coordinate widths, pattern colours and the
// layout of the endline control word
////////////////////////////////////////////////////////////

`default_nettype none

package video_pkg;

  // word widths
  localparam int pixel_w = 24;
  localparam int coord_w = 10;

  // hs column, keeps hs away from the vs cycle at column 0
  localparam int hs_offset = 3;

  // pattern colours, rgb888
  localparam logic [pixel_w-1:0] color_black  = 24'h000000;
  localparam logic [pixel_w-1:0] color_red    = 24'hff0000;
  localparam logic [pixel_w-1:0] color_green  = 24'h00ff00;
  localparam logic [pixel_w-1:0] color_blue   = 24'h0000ff;
  localparam logic [pixel_w-1:0] color_yellow = 24'hffff80;
  localparam logic [pixel_w-1:0] color_white  = 24'hffffff;
  localparam logic [pixel_w-1:0] color_purple = 24'ha00080;

  ////////////////////////////////////////////////////////////
  // endline word
  ////////////////////////////////////////////////////////////

  // slot index sits in the top bits, everything below is zero
  localparam int endline_slot_lsb = 13;
  localparam int slot_w           = pixel_w - endline_slot_lsb;

  // scaler slots for the two widths
  localparam logic [slot_w-1:0] slot_undocked = 11'd0;
  localparam logic [slot_w-1:0] slot_docked   = 11'd1;

endpackage

`default_nettype wire

/* hdl/test_signal_top.sv */
////////////////////////////////////////////////////////////
// test signal top level
// video timing and pattern chain plus the i2s tone source
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module test_signal_top #(
  parameter int h_total           = 400,
  parameter int h_bporch          = 10,
  parameter int h_active_undocked = 200,
  parameter int h_active_docked   = 320,
  parameter int v_total           = 512,
  parameter int v_bporch          = 10,
  parameter int v_active          = 180,
  parameter int tone_half_period  = 109
) (
  input  logic                          audgen_mclk,
  input  logic                          reset_n,
  input  logic                          docked,
  input  logic                          key_up,
  input  logic                          key_down,
  output logic [video_pkg::pixel_w-1:0] video_rgb,
  output logic                          video_de,
  output logic                          video_hs,
  output logic                          video_vs,
  output logic                          audio_sclk,
  output logic                          audio_lrck,
  output logic                          audio_dac
);
  import video_pkg::*;

  // timing to pattern
  logic [coord_w-1:0] x;
  logic [coord_w-1:0] y;
  logic               hs_pulse;
  logic               vs_pulse;
  logic               in_active;
  logic               first_row;
  logic               last_row;
  logic               first_col;
  logic               last_col;
  logic               endline_strobe;
  logic [slot_w-1:0]  endline_slot;
  logic               frame_docked;

  video_timing #(
    .h_total          (h_total),
    .h_bporch         (h_bporch),
    .h_active_undocked(h_active_undocked),
    .h_active_docked  (h_active_docked),
    .v_total          (v_total),
    .v_bporch         (v_bporch),
    .v_active         (v_active)
  ) timing0 (
    .audgen_mclk   (audgen_mclk),
    .reset_n       (reset_n),
    .docked        (docked),
    .x             (x),
    .y             (y),
    .hs_pulse      (hs_pulse),
    .vs_pulse      (vs_pulse),
    .in_active     (in_active),
    .first_row     (first_row),
    .last_row      (last_row),
    .first_col     (first_col),
    .last_col      (last_col),
    .endline_strobe(endline_strobe),
    .endline_slot  (endline_slot),
    .frame_docked  (frame_docked)
  );

  test_pattern pattern0 (
    .audgen_mclk   (audgen_mclk),
    .reset_n       (reset_n),
    .x             (x),
    .y             (y),
    .hs_pulse      (hs_pulse),
    .vs_pulse      (vs_pulse),
    .in_active     (in_active),
    .first_row     (first_row),
    .last_row      (last_row),
    .first_col     (first_col),
    .last_col      (last_col),
    .endline_strobe(endline_strobe),
    .endline_slot  (endline_slot),
    .frame_docked  (frame_docked),
    .key_up        (key_up),
    .key_down      (key_down),
    .video_rgb     (video_rgb),
    .video_de      (video_de),
    .video_hs      (video_hs),
    .video_vs      (video_vs)
  );

  // audio runs on its own
  i2s_tone_gen #(
    .tone_half_period(tone_half_period)
  ) tone0 (
    .audgen_mclk(audgen_mclk),
    .reset_n    (reset_n),
    .audio_sclk (audio_sclk),
    .audio_lrck (audio_lrck),
    .audio_dac  (audio_dac)
  );

endmodule

`default_nettype wire

/* list.f */
common/video_pkg.sv
common/audio_pkg.sv
video/video_timing.sv
video/test_pattern.sv
audio/i2s_tone_gen.sv
hdl/test_signal_top.sv
testbench/tb_test_signal.sv

/* testbench/tb_test_signal.sv */
////////////////////////////////////////////////////////////
// testbench for the test signal top level
// steps dock and key inputs over whole frames, checks every
// pixel against the raster rules, then checks i2s framing
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_test_signal;

  // small raster so whole frames stay cheap
  localparam int h_total   = 40;
  localparam int h_bporch  = 4;
  localparam int width_ud  = 12;
  localparam int width_d   = 20;
  localparam int v_total   = 24;
  localparam int v_bporch  = 3;
  localparam int v_active  = 14;
  localparam int tone_half = 3;

  localparam int clk_period   = 40;
  localparam int drive_delay  = 2;
  localparam int frame_clocks = h_total * v_total;
  localparam int last_line    = v_bporch + v_active - 1;
  localparam int hs_col       = 3;
  // i2s framing, 4 clocks per bit, 32 bits per channel
  localparam int bit_clocks   = 4;
  localparam int lrck_half    = 128;
  localparam int lead_zeros   = 4;
  localparam int n_steps      = 7;

  localparam logic [23:0] rgb_black  = 24'h000000;
  localparam logic [23:0] rgb_red    = 24'hff0000;
  localparam logic [23:0] rgb_green  = 24'h00ff00;
  localparam logic [23:0] rgb_blue   = 24'h0000ff;
  localparam logic [23:0] rgb_yellow = 24'hffff80;
  localparam logic [23:0] rgb_white  = 24'hffffff;
  localparam logic [23:0] rgb_purple = 24'ha00080;

  // one table row, applied for two frames
  typedef struct packed {
    logic        docked;
    logic        key_up;
    logic        key_down;
    logic        endline;
    logic [10:0] slot;
    logic [9:0]  width;
  } step_t;

  logic        audgen_mclk;
  logic        reset_n;
  logic        docked;
  logic        key_up;
  logic        key_down;
  logic [23:0] video_rgb;
  logic        video_de;
  logic        video_hs;
  logic        video_vs;
  logic        audio_sclk;
  logic        audio_lrck;
  logic        audio_dac;

  step_t steps [n_steps];
  int    test_errors [1:6];
  int    checks;

  test_signal_top #(
    .h_total          (h_total),
    .h_bporch         (h_bporch),
    .h_active_undocked(width_ud),
    .h_active_docked  (width_d),
    .v_total          (v_total),
    .v_bporch         (v_bporch),
    .v_active         (v_active),
    .tone_half_period (tone_half)
  ) dut0 (
    .audgen_mclk(audgen_mclk),
    .reset_n    (reset_n),
    .docked     (docked),
    .key_up     (key_up),
    .key_down   (key_down),
    .video_rgb  (video_rgb),
    .video_de   (video_de),
    .video_hs   (video_hs),
    .video_vs   (video_vs),
    .audio_sclk (audio_sclk),
    .audio_lrck (audio_lrck),
    .audio_dac  (audio_dac)
  );

  initial begin
    audgen_mclk = 1'b0;
    forever #(clk_period / 2) audgen_mclk = ~audgen_mclk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // outputs settled, inputs change here
  task automatic step_clock();
    @(posedge audgen_mclk);
    #drive_delay;
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("Result: FAILED");
    $finish;
  endtask

  task automatic check_bit(input int test_id, input string what, input logic got,
                           input logic exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %0t: test %0d %s is %b, expected %b", $time, test_id, what, got, exp);
      test_errors[test_id]++;
    end
  endtask

  task automatic check_rgb(input int test_id, input string what, input logic [23:0] got,
                           input logic [23:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %0t: test %0d %s is %h, expected %h", $time, test_id, what, got, exp);
      test_errors[test_id]++;
    end
  endtask

  task automatic check_count(input int test_id, input string what, input int got,
                             input int exp);
    checks++;
    assert (got == exp) else begin
      $display("ERR %0t: test %0d %s is %0d, expected %0d", $time, test_id, what, got, exp);
      test_errors[test_id]++;
    end
  endtask

  task automatic check_outputs_low(input int test_id);
    check_rgb(test_id, "video_rgb in reset", video_rgb, rgb_black);
    check_bit(test_id, "video_de in reset", video_de, 1'b0);
    check_bit(test_id, "video_hs in reset", video_hs, 1'b0);
    check_bit(test_id, "video_vs in reset", video_vs, 1'b0);
    check_bit(test_id, "audio_sclk in reset", audio_sclk, 1'b0);
    check_bit(test_id, "audio_lrck in reset", audio_lrck, 1'b0);
    check_bit(test_id, "audio_dac in reset", audio_dac, 1'b0);
  endtask

  // reset low for 3 clocks
  task automatic apply_reset(input int test_id);
    reset_n = 1'b0;
    for (int i = 0; i < 3; i++) begin
      step_clock();
      check_outputs_low(test_id);
    end
    reset_n = 1'b1;
  endtask

  task automatic wait_for_vs(output int gap);
    gap = 0;
    do begin
      step_clock();
      gap++;
      if (gap > frame_clocks + h_total) begin
        abort_run("no video_vs pulse within a frame");
      end
    end while (!video_vs);
  endtask

  task automatic wait_for_hs(output int gap);
    gap = 0;
    do begin
      step_clock();
      gap++;
      if (gap > 2 * h_total) begin
        abort_run("no video_hs pulse within two lines");
      end
    end while (!video_hs);
  endtask

  task automatic wait_lrck_toggle(output int gap);
    logic start;
    start = audio_lrck;
    gap = 0;
    do begin
      step_clock();
      gap++;
      if (gap > 2 * lrck_half) begin
        abort_run("audio_lrck stopped toggling");
      end
    end while (audio_lrck == start);
  endtask

  // tone level after a number of channel wraps
  function automatic logic tone_level(input int wraps);
    return ((wraps / tone_half) % 2) == 1;
  endfunction

  // one frame, starting at the vs sample
  task automatic check_frame(input int width, input logic frm_docked, input logic endline,
                             input logic [10:0] slot, input logic up, input logic down);
    int   col;
    int   row;
    int   de_count;
    logic active;
    logic dark;
    de_count = 0;
    // down always wins, up only lightens a docked frame
    dark = down || (frm_docked && !up);
    for (int p = 0; p < frame_clocks; p++) begin
      if (p > 0) begin
        step_clock();
      end
      col = p % h_total;
      row = p / h_total;
      active = (col >= h_bporch) && (col < h_bporch + width) &&
               (row >= v_bporch) && (row <= last_line);
      check_bit(2, "video_hs", video_hs, col == hs_col);
      check_bit(2, "video_vs", video_vs, (col == 0) && (row == 0));
      if ((row == last_line) && (col == h_bporch + width)) begin
        // endline slot, word only on a dock change
        check_bit(5, "video_de at endline", video_de, 1'b0);
        check_rgb(5, "endline word", video_rgb, endline ? {slot, 13'd0} : rgb_black);
      end else if (!active) begin
        check_bit(2, "video_de in blanking", video_de, 1'b0);
        check_rgb(2, "blanking colour", video_rgb, rgb_black);
      end else begin
        check_bit(2, "video_de in window", video_de, 1'b1);
        if (row == v_bporch) begin
          check_rgb(3, "top border", video_rgb, rgb_red);
        end else if (row == last_line) begin
          check_rgb(3, "bottom border", video_rgb, rgb_blue);
        end else if (col == h_bporch) begin
          check_rgb(3, "left border", video_rgb, rgb_green);
        end else if (col == h_bporch + width - 1) begin
          check_rgb(3, "right border", video_rgb, rgb_yellow);
        end else if (((col + row) % 2) == 1) begin
          check_rgb(4, "odd square", video_rgb, dark ? rgb_black : rgb_white);
        end else begin
          check_rgb(4, "even square", video_rgb, rgb_purple);
        end
      end
      if (video_de) begin
        de_count++;
      end
    end
    check_count(2, "de cycles per frame", de_count, v_active * width);
  endtask

  task automatic report_test(input int test_id, input string name);
    $display("test %0d %s: %s, %0d errors", test_id, name,
             (test_errors[test_id] == 0) ? "ok" : "mismatch", test_errors[test_id]);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int   gap;
    int   width;
    int   prev_width;
    int   total;
    logic prev_docked;
    logic frm_docked;
    logic lrck_prev;
    logic dac_exp;

    $timeformat(-9, 0, " ns", 0);
    reset_n  = 1'b0;
    docked   = 1'b0;
    key_up   = 1'b0;
    key_down = 1'b0;
    checks   = 0;
    for (int i = 1; i <= 6; i++) begin
      test_errors[i] = 0;
    end

    // docked, up, down, endline, slot, width after the switch
    steps[0] = '{1'b0, 1'b0, 1'b0, 1'b0, 11'd0, 10'd12};
    steps[1] = '{1'b0, 1'b0, 1'b1, 1'b0, 11'd0, 10'd12};
    steps[2] = '{1'b1, 1'b0, 1'b0, 1'b1, 11'd1, 10'd20};
    steps[3] = '{1'b1, 1'b1, 1'b0, 1'b0, 11'd0, 10'd20};
    steps[4] = '{1'b1, 1'b1, 1'b1, 1'b0, 11'd0, 10'd20};
    steps[5] = '{1'b0, 1'b0, 1'b0, 1'b1, 11'd0, 10'd12};
    steps[6] = '{1'b0, 1'b1, 1'b0, 1'b0, 11'd0, 10'd12};

    // reset and sync spacing
    apply_reset(1);
    wait_for_vs(gap);
    check_count(1, "clocks to first vs", gap, 1);
    wait_for_hs(gap);
    check_count(1, "vs to first hs", gap, hs_col);
    for (int line = 1; line < v_total; line++) begin
      wait_for_hs(gap);
      check_count(1, "hs period", gap, h_total);
    end
    wait_for_vs(gap);
    check_count(1, "last hs to vs", gap, h_total - hs_col);
    wait_for_vs(gap);
    check_count(1, "vs period", gap, frame_clocks);
    report_test(1, "reset and sync");

    // table, first frame still runs at the old width
    prev_width  = width_ud;
    prev_docked = 1'b0;
    for (int s = 0; s < n_steps; s++) begin
      for (int f = 0; f < 2; f++) begin
        wait_for_vs(gap);
        if (f == 0) begin
          docked   = steps[s].docked;
          key_up   = steps[s].key_up;
          key_down = steps[s].key_down;
        end
        width      = (f == 0) ? prev_width : int'(steps[s].width);
        frm_docked = (f == 0) ? prev_docked : steps[s].docked;
        check_frame(width, frm_docked, (f == 0) && steps[s].endline, steps[s].slot,
                    steps[s].key_up, steps[s].key_down);
      end
      prev_width  = int'(steps[s].width);
      prev_docked = steps[s].docked;
    end
    report_test(2, "data-enable window");
    report_test(3, "borders");
    report_test(4, "checker and keys");
    report_test(5, "width switch");

    // audio framing from a fresh reset
    apply_reset(6);
    wait_lrck_toggle(gap);
    check_count(6, "clocks to first lrck toggle", gap, lrck_half);
    for (int w = 1; w <= 9; w++) begin
      lrck_prev = audio_lrck;
      for (int k = 0; k < lrck_half; k++) begin
        if (k > 0) begin
          step_clock();
        end
        // one bit of delay, then the leading zeros, then the level
        if (k < bit_clocks) begin
          dac_exp = tone_level(w - 1);
        end else if (k < bit_clocks * (lead_zeros + 1)) begin
          dac_exp = 1'b0;
        end else begin
          dac_exp = tone_level(w);
        end
        check_bit(6, "audio_dac", audio_dac, dac_exp);
        check_bit(6, "audio_lrck inside a channel", audio_lrck, lrck_prev);
        // sclk high for the upper half of each bit
        check_bit(6, "audio_sclk", audio_sclk, (k % bit_clocks) >= (bit_clocks / 2));
      end
      step_clock();
      check_bit(6, "audio_lrck toggle", audio_lrck, !lrck_prev);
    end
    report_test(6, "audio");

    total = 0;
    for (int i = 1; i <= 6; i++) begin
      total += test_errors[i];
    end
    $display("checks run %0d, errors %0d", checks, total);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* video/test_pattern.sv */
////////////////////////////////////////////////////////////
// test pattern pixel stage
// picks border, checker or endline colour per position and
// registers rgb, de and sync toward the scaler
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module test_pattern (
  input  logic                          audgen_mclk,
  input  logic                          reset_n,
  input  logic [video_pkg::coord_w-1:0] x,
  input  logic [video_pkg::coord_w-1:0] y,
  input  logic                          hs_pulse,
  input  logic                          vs_pulse,
  input  logic                          in_active,
  input  logic                          first_row,
  input  logic                          last_row,
  input  logic                          first_col,
  input  logic                          last_col,
  input  logic                          endline_strobe,
  input  logic [video_pkg::slot_w-1:0]  endline_slot,
  input  logic                          frame_docked,
  input  logic                          key_up,
  input  logic                          key_down,
  output logic [video_pkg::pixel_w-1:0] video_rgb,
  output logic                          video_de,
  output logic                          video_hs,
  output logic                          video_vs
);
  import video_pkg::*;

  logic [pixel_w-1:0] endline_word;
  logic [pixel_w-1:0] next_rgb;
  // checker square that follows the keys
  logic               odd_square;
  logic               dark_squares;

  // slot index on top, zero below
  assign endline_word = {endline_slot, {endline_slot_lsb{1'b0}}};

  // column and row parity differ
  assign odd_square = x[0] ^ y[0];

  // down forces black, up forces white
  // otherwise docked frames default to black
  assign dark_squares = key_down || (frame_docked && !key_up);

  ////////////////////////////////////////////////////////////
  // colour select
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (endline_strobe) begin
      next_rgb = endline_word;
    end else if (!in_active) begin
      next_rgb = color_black;
    end else if (first_row) begin
      next_rgb = color_red;
    end else if (last_row) begin
      next_rgb = color_blue;
    end else if (first_col) begin
      next_rgb = color_green;
    end else if (last_col) begin
      next_rgb = color_yellow;
    end else if (odd_square) begin
      next_rgb = dark_squares ? color_black : color_white;
    end else begin
      next_rgb = color_purple;
    end
  end

  // one clock behind the counters
  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
    end else begin
      video_rgb <= next_rgb;
      video_de  <= in_active && !endline_strobe;
      video_hs  <= hs_pulse;
      video_vs  <= vs_pulse;
    end
  end

  // endline slot lies outside the window, so de stays low with the word
  a_endline_no_de : assert property (@(posedge audgen_mclk) disable iff (!reset_n)
    endline_strobe |-> !in_active ##1 !video_de);

endmodule

`default_nettype wire

/* video/video_timing.sv */
////////////////////////////////////////////////////////////
// video raster timing
// column/row counters, sync and window decode, and the
// dock-driven active width switch at the frame boundary
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module video_timing #(
  parameter int h_total           = 400,
  parameter int h_bporch          = 10,
  parameter int h_active_undocked = 200,
  parameter int h_active_docked   = 320,
  parameter int v_total           = 512,
  parameter int v_bporch          = 10,
  parameter int v_active          = 180
) (
  input  logic                          audgen_mclk,
  input  logic                          reset_n,
  input  logic                          docked,
  output logic [video_pkg::coord_w-1:0] x,
  output logic [video_pkg::coord_w-1:0] y,
  output logic                          hs_pulse,
  output logic                          vs_pulse,
  output logic                          in_active,
  output logic                          first_row,
  output logic                          last_row,
  output logic                          first_col,
  output logic                          last_col,
  output logic                          endline_strobe,
  output logic [video_pkg::slot_w-1:0]  endline_slot,
  output logic                          frame_docked
);
  import video_pkg::*;

  // raster positions in counter width
  localparam logic [coord_w-1:0] x_last   = coord_w'(h_total - 1);
  localparam logic [coord_w-1:0] y_last   = coord_w'(v_total - 1);
  localparam logic [coord_w-1:0] x_start  = coord_w'(h_bporch);
  localparam logic [coord_w-1:0] y_start  = coord_w'(v_bporch);
  localparam logic [coord_w-1:0] y_end    = coord_w'(v_bporch + v_active);
  localparam logic [coord_w-1:0] y_final  = coord_w'(v_bporch + v_active - 1);
  localparam logic [coord_w-1:0] width_ud = coord_w'(h_active_undocked);
  localparam logic [coord_w-1:0] width_d  = coord_w'(h_active_docked);

  // current width and the width for the next frame
  logic [coord_w-1:0] h_active;
  logic [coord_w-1:0] h_active_next;
  // first column past the active pixels
  logic [coord_w-1:0] x_end;
  // docked level seen at the last endline check
  logic               docked_last;
  logic               endline_pos;

  assign x_end = h_active + x_start;

  ////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      x        <= '0;
      y        <= '0;
      h_active <= width_ud;
    end else if (x == x_last) begin
      x <= '0;
      if (y == y_last) begin
        y <= '0;
        // width only changes between frames
        h_active <= h_active_next;
      end else begin
        y <= y + 1'b1;
      end
    end else begin
      x <= x + 1'b1;
    end
  end

  // sync points
  assign vs_pulse = (x == '0) && (y == '0);
  assign hs_pulse = (x == coord_w'(hs_offset));

  // active window and its edges
  assign in_active = (x >= x_start) && (x < x_end) && (y >= y_start) && (y < y_end);
  assign first_row = (y == y_start);
  assign last_row  = (y == y_final);
  assign first_col = (x == x_start);
  assign last_col  = (x == x_end - 1'b1);

  ////////////////////////////////////////////////////////////
  // width switch
  ////////////////////////////////////////////////////////////

  // just past the last pixel of the last active line
  assign endline_pos    = (x == x_end) && (y == y_final);
  assign endline_strobe = endline_pos && (docked != docked_last);
  assign endline_slot   = docked ? slot_docked : slot_undocked;
  assign frame_docked   = docked_last;

  // starts undocked
  always_ff @(posedge audgen_mclk or negedge reset_n) begin
    if (!reset_n) begin
      docked_last   <= 1'b0;
      h_active_next <= width_ud;
    end else if (endline_strobe) begin
      docked_last   <= docked;
      h_active_next <= docked ? width_d : width_ud;
    end
  end

  // vs at column 0, hs at hs_offset, never the same clock
  a_sync_apart : assert property (@(posedge audgen_mclk) disable iff (!reset_n)
    !(hs_pulse && vs_pulse));

endmodule

`default_nettype wire
